/* build.f */
+incdir+common
common/vic_bus_pkg.sv
common/vic_video_pkg.sv
bus/cpu_bus_port.sv
regs/vic_regs.sv
source/raster_timer.sv
source/color_scaler.sv
source/vic_board_top.sv
sim/vic_board_checker.sv
sim/vic_board_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the vic board simulation with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
rm -f sim.log

verilator --binary --timing --assert \
  --timescale 1ns/100ps \
  --top-module vic_board_tb \
  -f build.f

# the exit status of tee is what set -e sees, the log decides the result
./obj_dir/Vvic_board_tb +verilator+error+limit+100 | tee sim.log

if grep -qx "SIMULATION PASSED" sim.log; then
  echo "run_sim: testbench passed"
else
  echo "run_sim: testbench failed, see sim.log"
  exit 1
fi

/* sim/vic_board_tb.sv */
// vic board testbench
// register accesses from a table over the cpu bus, raster irq, video colors
// and line/frame timing for pal and ntsc
`include "vic_cfg.svh"

module vic_board_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import vic_bus_pkg::*;

  typedef struct {
    string      name;
    logic       is_read;
    logic [5:0] addr;
    logic [7:0] wdata;
    logic [7:0] exp;
  } access_t;

  logic       clk_col4x_pal;
  logic       arst_n;
  logic       standard_sw;
  logic       ce;
  logic       rw;
  logic [5:0] adr;
  logic [7:0] dbi;
  logic [7:0] dbo;
  logic       dbo_en;
  logic       ls245_data_dir;
  logic       irq;
  logic       hsync;
  logic       vsync;
  logic       active;
  logic [7:0] red;
  logic [7:0] green;
  logic [7:0] blue;

  access_t    tbl [$];
  bit         tbl_ready;
  logic [3:0] border_val;
  logic [3:0] bg_val;
  logic       hs_d;
  logic       vs_d;
  int         clk_n;          // rising edges since reset release
  int         hcnt;           // clocks since last hsync rise
  int         lcnt;           // lines since last vsync rise
  int         last_hper;
  int         last_lines;
  int         frames;

  vic_board_top u_dut (
    .clk_col4x_pal  (clk_col4x_pal),
    .arst_n         (arst_n),
    .standard_sw    (standard_sw),
    .ce             (ce),
    .rw             (rw),
    .adr            (adr),
    .dbi            (dbi),
    .dbo            (dbo),
    .dbo_en         (dbo_en),
    .ls245_data_dir (ls245_data_dir),
    .irq            (irq),
    .hsync          (hsync),
    .vsync          (vsync),
    .active         (active),
    .red            (red),
    .green          (green),
    .blue           (blue)
  );

  initial begin
    clk_col4x_pal = 1'b0;
    forever #10 clk_col4x_pal = ~clk_col4x_pal;   // 20 ns period
  end

  // 6-bit channel to 8 bits, v * 255 / 63 rounded down
  function automatic logic [7:0] widen(input logic [5:0] v);
    int unsigned p;
    p = v * 255;
    return 8'(p / 63);
  endfunction

  function automatic logic [23:0] color_of(input logic [3:0] idx);
    logic [17:0] e;
    e = vic_video_pkg::vic_palette[idx];
    return {widen(e[17:12]), widen(e[11:6]), widen(e[5:0])};
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      fail_run($sformatf("ERR %s expected 0x%0h actual 0x%0h", name, exp, act));
    end
  endtask

  task automatic add_row(input string name, input logic is_read, input logic [5:0] addr,
                         input logic [7:0] wdata, input logic [7:0] exp);
    access_t r;
    r.name    = name;
    r.is_read = is_read;
    r.addr    = addr;
    r.wdata   = wdata;
    r.exp     = exp;
    tbl.push_back(r);
  endtask

  // one cpu cycle: ce low 10 clocks, then high 10 clocks
  task automatic bus_access(input string name, input logic is_read, input logic [5:0] a,
                            input logic [7:0] d, output logic [7:0] rd);
    logic seen;
    seen = 1'b0;
    rd   = 8'h00;
    @(negedge clk_col4x_pal);
    ce  = 1'b0;
    rw  = is_read;
    adr = a;
    dbi = d;
    repeat (10) begin
      @(negedge clk_col4x_pal);
      if (is_read && seen) begin
        compare($sformatf("%s_dbo_hold", name), 32'h3, 32'({dbo_en, ls245_data_dir}));
      end
      if (is_read && dbo_en && !seen) begin
        rd   = dbo;                                  // first clock of the drive window
        seen = 1'b1;
        compare($sformatf("%s_dir", name), 32'd1, 32'(ls245_data_dir));
      end
      if (!is_read) begin
        compare($sformatf("%s_dbo_en", name), 32'd0, 32'({dbo_en, ls245_data_dir}));
      end
    end
    if (is_read && !seen) fail_run($sformatf("%s: read never raised dbo_en", name));
    ce = 1'b1;
    rw = 1'b1;
    repeat (10) @(negedge clk_col4x_pal);
    compare($sformatf("%s_release", name), 32'd0, 32'({dbo_en, ls245_data_dir}));
  endtask

  task automatic wait_frame_start(input string name, input int bound, input logic irq_high);
    int f0;
    int n;
    f0 = frames;
    n  = 0;
    while (frames == f0) begin
      if (n == bound) fail_run($sformatf("%s: no frame start in %0d clocks", name, bound));
      @(negedge clk_col4x_pal);
      if (irq_high) compare($sformatf("%s_irq", name), 32'd1, 32'(irq));
      n++;
    end
  endtask

  // video output lags this count by two clocks
  always @(posedge clk_col4x_pal) begin
    if (arst_n) clk_n <= clk_n + 1;
  end

  // line period and frame length seen on the video outputs
  always @(negedge clk_col4x_pal) begin
    if (!arst_n) begin
      hs_d       <= 1'b1;
      vs_d       <= 1'b1;
      hcnt       <= 0;
      lcnt       <= 0;
      last_hper  <= 0;
      last_lines <= 0;
      frames     <= 0;
    end else begin
      if (hsync && !hs_d) begin
        last_hper <= hcnt;
        hcnt      <= 1;
      end else begin
        hcnt <= hcnt + 1;
      end
      if (vsync && !vs_d) begin
        last_lines <= lcnt;
        lcnt       <= 1;                             // line 0 starts with vsync
        frames     <= frames + 1;
      end else if (hsync && !hs_d) begin
        lcnt <= lcnt + 1;
      end
      hs_d <= hsync;
      vs_d <= vsync;
    end
  end

  always @(negedge clk_col4x_pal) begin
    if (u_dut.u_checker.any_fail) fail_run("a bound protocol assertion failed");
  end

  initial begin
    longint limit_ns;
    wait (tbl_ready);
    limit_ns = (longint'(tbl.size()) * 20 + 3 * `VIC_NTSC_LINE_LEN * `VIC_NTSC_LINES) * 20;
    #(limit_ns);
    fail_run("timeout: the run did not finish in the expected time");
  end

  initial begin
    logic [7:0] rd;
    logic [7:0] rnd_border;
    logic [7:0] rnd_bg;
    logic [3:0] exp_idx;
    logic [2:0] exp_sync;
    int         vx;
    int         vy;
    int         n;
    arst_n      = 1'b0;
    standard_sw = 1'b0;
    ce          = 1'b1;
    rw          = 1'b1;
    adr         = 6'h00;
    dbi         = 8'h00;
    void'($urandom(32'hff03ef5b));
    rnd_border = 8'($urandom);
    rnd_bg     = 8'($urandom);
    if (rnd_bg[3:0] == rnd_border[3:0]) rnd_bg[3:0] = rnd_border[3:0] + 4'd1;  // tell them apart
    border_val = rnd_border[3:0];
    bg_val     = rnd_bg[3:0];

    add_row("rst_border", 1'b1, ra_border, 8'h00, {4'hF, 4'(`VIC_RST_BORDER)});
    add_row("rst_bg", 1'b1, ra_bg, 8'h00, {4'hF, 4'(`VIC_RST_BG)});
    add_row("rst_model", 1'b1, ra_model, 8'h00, 8'hFF);     // pal
    add_row("rst_irq_en", 1'b1, ra_irq_en, 8'h00, 8'hFE);
    add_row("rst_irq_stat", 1'b1, ra_irq_stat, 8'h00, 8'hFE);
    add_row("hole_00", 1'b1, 6'h00, 8'h00, 8'hFF);
    add_row("hole_2e", 1'b1, 6'h2E, 8'h00, 8'hFF);
    add_row("wr_border", 1'b0, ra_border, rnd_border, 8'h00);
    add_row("rd_border", 1'b1, ra_border, 8'h00, {4'hF, rnd_border[3:0]});
    add_row("wr_bg", 1'b0, ra_bg, rnd_bg, 8'h00);
    add_row("rd_bg", 1'b1, ra_bg, 8'h00, {4'hF, rnd_bg[3:0]});
    add_row("wr_ctrl", 1'b0, ra_ctrl, 8'h80, 8'h00);        // compare bit 8
    add_row("wr_raster", 1'b0, ra_raster, 8'h05, 8'h00);    // compare = 261
    add_row("rd_ctrl", 1'b1, ra_ctrl, 8'h00, 8'h7F);        // live bit 8, line still below 256
    add_row("wr_irq_en", 1'b0, ra_irq_en, 8'h01, 8'h00);
    add_row("rd_irq_en", 1'b1, ra_irq_en, 8'h00, 8'hFF);
    add_row("wr_irq_off", 1'b0, ra_irq_en, 8'h00, 8'h00);   // masked for the frame checks
    add_row("rd_irq_off", 1'b1, ra_irq_en, 8'h00, 8'hFE);
    add_row("rd_hole_05", 1'b1, 6'h05, 8'h00, 8'hFF);
    tbl_ready = 1'b1;

    repeat (2) @(negedge clk_col4x_pal);
    arst_n = 1'b1;

    foreach (tbl[i]) begin
      bus_access(tbl[i].name, tbl[i].is_read, tbl[i].addr, tbl[i].wdata, rd);
      if (tbl[i].is_read) compare(tbl[i].name, 32'(tbl[i].exp), 32'(rd));
      compare($sformatf("%s_irq", tbl[i].name), 32'd1, 32'(irq));
    end

    // lines 50 to 52 of the first frame, top border edge, window edges and blanking
    while (clk_n < 2 + 50 * `VIC_PAL_LINE_LEN) @(negedge clk_col4x_pal);
    for (n = 0; n < 3 * `VIC_PAL_LINE_LEN; n++) begin
      vx       = (clk_n - 2) % `VIC_PAL_LINE_LEN;
      vy       = (clk_n - 2) / `VIC_PAL_LINE_LEN;
      exp_sync = {vx < `VIC_HSYNC_LEN, vy < `VIC_VSYNC_LINES,
                  (vx >= `VIC_ACT_X0) && (vx <= `VIC_ACT_X1) &&
                  (vy >= `VIC_ACT_Y0) && (vy <= `VIC_ACT_Y1)};
      if (exp_sync[2] || exp_sync[1]) exp_idx = 4'd0;
      else if (exp_sync[0]) exp_idx = bg_val;
      else exp_idx = border_val;
      compare("video_sync", 32'(exp_sync), 32'({hsync, vsync, active}));
      compare("video_rgb", 32'(color_of(exp_idx)), 32'({red, green, blue}));
      @(negedge clk_col4x_pal);
    end
    compare("pal_hsync_period", 32'(`VIC_PAL_LINE_LEN), 32'(last_hper));

    standard_sw = 1'b1;
    repeat (4) @(negedge clk_col4x_pal);
    standard_sw = 1'b0;
    bus_access("model_ntsc", 1'b1, ra_model, 8'h00, rd);
    compare("model_ntsc", 32'hFE, 32'(rd));
    bus_access("stat_pre_clear", 1'b0, ra_irq_stat, 8'h01, rd);  // only line 261 sets it again

    // line 261 passes in this frame with the irq masked
    wait_frame_start("frame1", `VIC_PAL_LINE_LEN * `VIC_PAL_LINES + 200, 1'b1);
    bus_access("stat_masked", 1'b1, ra_irq_stat, 8'h00, rd);
    compare("stat_masked", 32'hFF, 32'(rd));

    bus_access("cmp_line5", 1'b0, ra_ctrl, 8'h00, rd);           // compare back to 5
    bus_access("stat_clear", 1'b0, ra_irq_stat, 8'h01, rd);
    bus_access("irq_enable", 1'b0, ra_irq_en, 8'h01, rd);
    n = 0;
    while (irq) begin
      if (n == `VIC_NTSC_LINE_LEN * `VIC_NTSC_LINES) fail_run("raster irq stayed high a frame");
      @(negedge clk_col4x_pal);
      n++;
    end
    bus_access("stat_enabled", 1'b1, ra_irq_stat, 8'h00, rd);
    compare("stat_enabled", 32'hFF, 32'(rd));
    bus_access("stat_ack", 1'b0, ra_irq_stat, 8'h01, rd);
    compare("irq_cleared", 32'd1, 32'(irq));

    wait_frame_start("frame2", `VIC_NTSC_LINE_LEN * `VIC_NTSC_LINES + 200, 1'b0);
    compare("ntsc_hsync_period", 32'(`VIC_NTSC_LINE_LEN), 32'(last_hper));
    compare("ntsc_frame_lines", 32'(`VIC_NTSC_LINES), 32'(last_lines));

    if (u_dut.u_checker.any_fail) begin
      fail_run("a bound protocol assertion failed");
    end else begin
      $display("SIMULATION PASSED");
      $finish;
    end
  end

endmodule

/* sim/vic_board_checker.sv */
// vic board protocol checker
// bound into the board top, watches the req/ack handshake, the data bus
// drive window and the raster irq line
module vic_board_checker (
  input logic clk_col4x_pal,
  input logic arst_n,
  input logic req,
  input logic ack,
  input logic dbo_en,
  input logic ce_sync,      // bus port synchronized chip enable
  input logic irq,
  input logic irq_en        // register block irq enable bit
);
  timeunit 1ns;
  timeprecision 100ps;

  bit  fail_ack;
  bit  fail_req;
  bit  fail_dbo;
  bit  fail_irq;
  wire any_fail = fail_ack | fail_req | fail_dbo | fail_irq;  // polled by the testbench

  // phase 2 only answers a pending request
  ack_needs_req: assert property (@(posedge clk_col4x_pal) disable iff (!arst_n)
    $rose(ack) |-> req)
    else begin
      fail_ack = 1'b1;
      $error("ack rose while req was low");
    end

  // requester keeps req up until phase 2
  req_held: assert property (@(posedge clk_col4x_pal) disable iff (!arst_n)
    $fell(req) |-> ack)
    else begin
      fail_req = 1'b1;
      $error("req dropped before ack");
    end

  // drive ends the cycle after the cpu releases ce
  dbo_window: assert property (@(posedge clk_col4x_pal) disable iff (!arst_n)
    ce_sync |=> !dbo_en)
    else begin
      fail_dbo = 1'b1;
      $error("dbo_en high with ce released");
    end

  // irq register lags the enable by one clock
  irq_masked: assert property (@(posedge clk_col4x_pal) disable iff (!arst_n)
    !irq_en |=> irq)
    else begin
      fail_irq = 1'b1;
      $error("irq low with irq enable clear");
    end

endmodule

bind vic_board_top vic_board_checker u_checker (
  .clk_col4x_pal (clk_col4x_pal),
  .arst_n        (arst_n),
  .req           (req),
  .ack           (ack),
  .dbo_en        (dbo_en),
  .ce_sync       (u_port.ce_sync),
  .irq           (irq),
  .irq_en        (u_regs.irq_en)
);

/* source/vic_board_top.sv */
// vic board top level
// cpu bus port, register block, raster timer and color scaler on col4x;
// the fpga wrapper turns dbo/dbo_en into the tristate data pads
module vic_board_top (
  input  logic       clk_col4x_pal,
  input  logic       arst_n,
  input  logic       standard_sw,
  input  logic       ce,
  input  logic       rw,
  input  logic [5:0] adr,
  input  logic [7:0] dbi,
  output logic [7:0] dbo,
  output logic       dbo_en,
  output logic       ls245_data_dir,   // data transceiver points to the cpu on reads
  output logic       irq,
  output logic       hsync,
  output logic       vsync,
  output logic       active,
  output logic [7:0] red,
  output logic [7:0] green,
  output logic [7:0] blue
);
  import vic_bus_pkg::*;
  import vic_video_pkg::*;

  logic        req;
  logic        ack;
  reg_req_t    req_data;
  reg_rsp_t    rsp;
  chip_e       chip;
  logic [8:0]  raster_cmp;
  logic [3:0]  border;
  logic [3:0]  bg;
  raster_pos_t pos;
  sync_t       raw_sync;   // aligned with pos
  sync_t       vid_sync;   // aligned with rgb
  logic        cmp_hit;
  rgb_t        rgb;

  cpu_bus_port u_port (
    .clk_col4x_pal (clk_col4x_pal),
    .arst_n        (arst_n),
    .ce            (ce),
    .rw            (rw),
    .adr           (adr),
    .dbi           (dbi),
    .dbo           (dbo),
    .dbo_en        (dbo_en),
    .req           (req),
    .req_data      (req_data),
    .ack           (ack),
    .rsp           (rsp)
  );

  vic_regs u_regs (
    .clk_col4x_pal (clk_col4x_pal),
    .arst_n        (arst_n),
    .req           (req),
    .req_data      (req_data),
    .ack           (ack),
    .rsp           (rsp),
    .standard_sw   (standard_sw),
    .pos           (pos),
    .cmp_hit       (cmp_hit),
    .chip          (chip),
    .raster_cmp    (raster_cmp),
    .border        (border),
    .bg            (bg),
    .irq           (irq)
  );

  raster_timer u_timer (
    .clk_col4x_pal (clk_col4x_pal),
    .arst_n        (arst_n),
    .chip          (chip),
    .raster_cmp    (raster_cmp),
    .pos           (pos),
    .sync          (raw_sync),
    .cmp_hit       (cmp_hit)
  );

  color_scaler u_scaler (
    .clk_col4x_pal (clk_col4x_pal),
    .arst_n        (arst_n),
    .sync_in       (raw_sync),
    .border        (border),
    .bg            (bg),
    .rgb           (rgb),
    .sync_out      (vid_sync)
  );

  assign ls245_data_dir = dbo_en;
  assign hsync          = vid_sync.hsync;
  assign vsync          = vid_sync.vsync;
  assign active         = vid_sync.active;
  assign red            = rgb.red;
  assign green          = rgb.green;
  assign blue           = rgb.blue;

endmodule

/* source/color_scaler.sv */
// color scaler
// picks border, background or black per position, looks the index up in the
// 6-bit palette and widens each channel to 8 bits; two register stages
module color_scaler (
  input  logic                 clk_col4x_pal,
  input  logic                 arst_n,
  input  vic_video_pkg::sync_t sync_in,
  input  logic [3:0]           border,
  input  logic [3:0]           bg,
  output vic_video_pkg::rgb_t  rgb,
  output vic_video_pkg::sync_t sync_out
);
  import vic_video_pkg::*;

  logic [3:0]  idx;        // stage 1 color index
  sync_t       sync_d;     // stage 1 sync
  logic [17:0] pal_ent;

  // v * 255 / 63, rounded down
  function automatic logic [7:0] scale6(input logic [5:0] v);
    logic [13:0] prod;
    prod = 14'(v) * 14'd255;
    return 8'(prod / 14'd63);
  endfunction

  assign pal_ent = vic_palette[idx];

  always_ff @(posedge clk_col4x_pal or negedge arst_n) begin
    if (!arst_n) begin
      idx    <= 4'd0;
      sync_d <= sync_rst;
    end else begin
      if (sync_in.hsync || sync_in.vsync) idx <= 4'd0;  // blank to black
      else if (sync_in.active) idx <= bg;
      else idx <= border;
      sync_d <= sync_in;
    end
  end

  always_ff @(posedge clk_col4x_pal or negedge arst_n) begin
    if (!arst_n) begin
      rgb      <= '0;
      sync_out <= sync_rst;
    end else begin
      rgb.red   <= scale6(pal_ent[17:12]);
      rgb.green <= scale6(pal_ent[11:6]);
      rgb.blue  <= scale6(pal_ent[5:0]);
      sync_out  <= sync_d;                // keeps sync aligned with rgb
    end
  end

endmodule

/* source/raster_timer.sv */
// raster timer
// x and line counters for pal or ntsc geometry, sync and display window,
// and the raster compare pulse; all outputs registered and aligned with pos
`include "vic_cfg.svh"

module raster_timer (
  input  logic                        clk_col4x_pal,
  input  logic                        arst_n,
  input  vic_bus_pkg::chip_e          chip,
  input  logic [8:0]                  raster_cmp,
  output vic_video_pkg::raster_pos_t  pos,
  output vic_video_pkg::sync_t        sync,
  output logic                        cmp_hit
);
  import vic_bus_pkg::*;
  import vic_video_pkg::*;

  localparam logic [6:0] pal_x_last  = 7'(`VIC_PAL_LINE_LEN - 1);
  localparam logic [6:0] ntsc_x_last = 7'(`VIC_NTSC_LINE_LEN - 1);
  localparam logic [8:0] pal_y_last  = 9'(`VIC_PAL_LINES - 1);
  localparam logic [8:0] ntsc_y_last = 9'(`VIC_NTSC_LINES - 1);
  localparam logic [6:0] hsync_end   = 7'(`VIC_HSYNC_LEN);
  localparam logic [8:0] vsync_end   = 9'(`VIC_VSYNC_LINES);
  localparam logic [6:0] act_x0      = 7'(`VIC_ACT_X0);
  localparam logic [6:0] act_x1      = 7'(`VIC_ACT_X1);
  localparam logic [8:0] act_y0      = 9'(`VIC_ACT_Y0);
  localparam logic [8:0] act_y1      = 9'(`VIC_ACT_Y1);

  chip_e       frame_chip;   // model in force for the current frame
  logic [6:0]  x_last;
  logic [8:0]  y_last;
  logic        frame_end;
  raster_pos_t nxt;
  sync_t       nxt_sync;

  assign x_last = (frame_chip == chip_pal) ? pal_x_last : ntsc_x_last;
  assign y_last = (frame_chip == chip_pal) ? pal_y_last : ntsc_y_last;

  always_comb begin
    nxt       = pos;
    frame_end = 1'b0;
    if (pos.x == x_last) begin
      nxt.x = '0;
      if (pos.line == y_last) begin
        nxt.line  = '0;
        frame_end = 1'b1;                 // wrap to 0,0
      end else begin
        nxt.line = pos.line + 9'd1;
      end
    end else begin
      nxt.x = pos.x + 7'd1;
    end
  end

  // decode from the next position so flags land with pos
  always_comb begin
    nxt_sync.hsync  = (nxt.x < hsync_end);
    nxt_sync.vsync  = (nxt.line < vsync_end);
    nxt_sync.active = (nxt.x >= act_x0) && (nxt.x <= act_x1) &&
                      (nxt.line >= act_y0) && (nxt.line <= act_y1);
  end

  always_ff @(posedge clk_col4x_pal or negedge arst_n) begin
    if (!arst_n) begin
      pos        <= '0;
      sync       <= sync_rst;
      cmp_hit    <= 1'b0;
      frame_chip <= chip_pal;
    end else begin
      pos     <= nxt;
      sync    <= nxt_sync;
      cmp_hit <= (nxt.x == '0) && (nxt.line == raster_cmp);  // once per line start
      if (frame_end) frame_chip <= chip;  // model change takes effect here
    end
  end

endmodule

/* regs/vic_regs.sv */
// vic register block
// answers req/ack accesses, holds raster compare, irq, colors and chip model,
// and drives the raster irq line
`include "vic_cfg.svh"

module vic_regs (
  input  logic                       clk_col4x_pal,
  input  logic                       arst_n,
  input  logic                       req,
  input  vic_bus_pkg::reg_req_t      req_data,
  output logic                       ack,
  output vic_bus_pkg::reg_rsp_t      rsp,
  input  logic                       standard_sw,   // video standard toggle
  input  vic_video_pkg::raster_pos_t pos,
  input  logic                       cmp_hit,
  output vic_bus_pkg::chip_e         chip,
  output logic [8:0]                 raster_cmp,
  output logic [3:0]                 border,
  output logic [3:0]                 bg,
  output logic                       irq            // low active
);
  import vic_bus_pkg::*;

  logic       irq_en;
  logic       irq_stat;
  logic       sw_meta;
  logic       sw_sync;
  logic       sw_sync_d;
  logic       sw_rise;
  logic       access;      // request not yet acked
  logic       wr_acc;
  logic [7:0] rd_val;

  assign access  = req & ~ack;
  assign wr_acc  = access & (req_data.op == op_write);
  assign sw_rise = sw_sync & ~sw_sync_d;

  // read mux, unused bits and holes read as 1
  always_comb begin
    case (req_data.addr)
      ra_ctrl:     rd_val = {pos.line[8], 7'h7F};   // live raster bit 8
      ra_raster:   rd_val = pos.line[7:0];
      ra_irq_stat: rd_val = {7'h7F, irq_stat};
      ra_irq_en:   rd_val = {7'h7F, irq_en};
      ra_border:   rd_val = {4'hF, border};
      ra_bg:       rd_val = {4'hF, bg};
      ra_model:    rd_val = {7'h7F, chip};
      default:     rd_val = 8'hFF;
    endcase
  end

  // switch is a slow mechanical input
  always_ff @(posedge clk_col4x_pal or negedge arst_n) begin
    if (!arst_n) begin
      sw_meta   <= 1'b0;
      sw_sync   <= 1'b0;
      sw_sync_d <= 1'b0;
    end else begin
      sw_meta   <= standard_sw;
      sw_sync   <= sw_meta;
      sw_sync_d <= sw_sync;
    end
  end

  always_ff @(posedge clk_col4x_pal or negedge arst_n) begin
    if (!arst_n) begin
      ack        <= 1'b0;
      chip       <= chip_pal;
      raster_cmp <= '0;
      irq_en     <= 1'b0;
      irq_stat   <= 1'b0;
      border     <= 4'(`VIC_RST_BORDER);
      bg         <= 4'(`VIC_RST_BG);
      irq        <= 1'b1;
    end else begin
      if (access) ack <= 1'b1;            // phase 2, one cycle after req
      else if (!req) ack <= 1'b0;         // phase 4

      if (sw_rise) chip <= (chip == chip_pal) ? chip_ntsc : chip_pal;

      if (wr_acc) begin
        case (req_data.addr)
          ra_ctrl:     raster_cmp[8]   <= req_data.wdata[7];
          ra_raster:   raster_cmp[7:0] <= req_data.wdata;
          ra_irq_stat: if (req_data.wdata[0]) irq_stat <= 1'b0;  // write 1 clears
          ra_irq_en:   irq_en <= req_data.wdata[0];
          ra_border:   border <= req_data.wdata[3:0];
          ra_bg:       bg     <= req_data.wdata[3:0];
          ra_model:    chip   <= chip_e'(req_data.wdata[0]);
          default: begin
          end
        endcase
      end

      // a hit in the clearing cycle is not lost
      if (cmp_hit) irq_stat <= 1'b1;

      irq <= ~(irq_stat & irq_en);
    end
  end

  // response payload, sampled with ack
  always_ff @(posedge clk_col4x_pal) begin
    if (access) rsp.rdata <= rd_val;
  end

endmodule

/* bus/cpu_bus_port.sv */
// cpu bus port
// samples ce/rw through two flops, turns each ce-low access into one req/ack
// transfer and holds read data on dbo until the cpu lets go of ce
module cpu_bus_port (
  input  logic                  clk_col4x_pal,
  input  logic                  arst_n,
  input  logic                  ce,        // chip enable, low active
  input  logic                  rw,        // high read, low write
  input  logic [5:0]            adr,
  input  logic [7:0]            dbi,
  output logic [7:0]            dbo,
  output logic                  dbo_en,    // cpu read in progress, drive data bus
  output logic                  req,
  output vic_bus_pkg::reg_req_t req_data,
  input  logic                  ack,
  input  vic_bus_pkg::reg_rsp_t rsp
);
  import vic_bus_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_wait_ack,
    st_wait_release
  } port_st_e;

  port_st_e st;
  logic     ce_meta;      // first synchronizer stage
  logic     ce_sync;      // synchronized ce
  logic     ce_sync_d;    // previous ce_sync, for edge detect
  logic     rw_meta;
  logic     rw_sync;      // aligned with ce_sync
  logic     ce_fall;      // start of a cpu access
  logic     start;
  logic     done;         // ack seen, transfer complete

  assign ce_fall = ce_sync_d & ~ce_sync;
  assign start   = (st == st_idle) & ce_fall;  // ce-low during a transfer is ignored
  assign done    = (st == st_wait_ack) & ack;

  // strobes idle high
  always_ff @(posedge clk_col4x_pal or negedge arst_n) begin
    if (!arst_n) begin
      ce_meta   <= 1'b1;
      ce_sync   <= 1'b1;
      ce_sync_d <= 1'b1;
      rw_meta   <= 1'b1;
      rw_sync   <= 1'b1;
    end else begin
      ce_meta   <= ce;
      ce_sync   <= ce_meta;
      ce_sync_d <= ce_sync;
      rw_meta   <= rw;
      rw_sync   <= rw_meta;
    end
  end

  // requester half of the four-phase handshake
  always_ff @(posedge clk_col4x_pal or negedge arst_n) begin
    if (!arst_n) begin
      st     <= st_idle;
      req    <= 1'b0;
      dbo_en <= 1'b0;
    end else begin
      if (ce_sync) dbo_en <= 1'b0;        // cpu has released the chip
      case (st)
        st_idle: begin
          if (start) begin
            req <= 1'b1;
            st  <= st_wait_ack;
          end
        end
        st_wait_ack: begin
          if (ack) begin
            req    <= 1'b0;                           // phase 3
            dbo_en <= (req_data.op == op_read);
            st     <= st_wait_release;
          end
        end
        st_wait_release: begin
          if (!ack) st <= st_idle;        // phase 4 seen, next req allowed
        end
        default: st <= st_idle;
      endcase
    end
  end

  // adr/dbi are stable by the time the synchronized ce falls
  always_ff @(posedge clk_col4x_pal) begin
    if (start) begin
      req_data.op    <= reg_op_e'(rw_sync);
      req_data.addr  <= adr;
      req_data.wdata <= dbi;
    end
    if (done) dbo <= rsp.rdata;           // rsp valid while ack high
  end

endmodule

/* common/vic_video_pkg.sv */
// vic video-side types
// raster position, sync group, output color and the 6-bit palette
package vic_video_pkg;

  typedef struct packed {
    logic [6:0] x;       // position in line
    logic [8:0] line;    // raster line
  } raster_pos_t;

  typedef struct packed {
    logic hsync;
    logic vsync;
    logic active;        // inside display window
  } sync_t;

  typedef struct packed {
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
  } rgb_t;

  // sync state at x = 0, line = 0
  localparam sync_t sync_rst = '{hsync: 1'b1, vsync: 1'b1, active: 1'b0};

  // {red, green, blue}, 6 bits each
  localparam logic [17:0] vic_palette [0:15] = '{
    {6'h00, 6'h00, 6'h00},  // black
    {6'h3F, 6'h3F, 6'h3F},  // white
    {6'h1A, 6'h0D, 6'h0A},  // red
    {6'h1C, 6'h29, 6'h2C},  // cyan
    {6'h1B, 6'h0F, 6'h21},  // purple
    {6'h16, 6'h23, 6'h10},  // green
    {6'h0D, 6'h0A, 6'h1E},  // blue
    {6'h2E, 6'h31, 6'h1B},  // yellow
    {6'h1B, 6'h13, 6'h09},  // orange
    {6'h10, 6'h0E, 6'h00},  // brown
    {6'h26, 6'h19, 6'h16},  // light red
    {6'h11, 6'h11, 6'h11},  // dark grey
    {6'h1B, 6'h1B, 6'h1B},  // grey
    {6'h26, 6'h34, 6'h21},  // light green
    {6'h1B, 6'h17, 6'h2D},  // light blue
    {6'h25, 6'h25, 6'h25}   // light grey
  };

endpackage

/* common/vic_bus_pkg.sv */
// vic bus-side types
// chip model, register map and the req/ack payloads between bus port and registers
package vic_bus_pkg;

  // bit 0 of ra_model, 1 selects pal
  typedef enum logic {
    chip_ntsc = 1'b0,
    chip_pal  = 1'b1
  } chip_e;

  // same polarity as the cpu rw pin
  typedef enum logic {
    op_write = 1'b0,
    op_read  = 1'b1
  } reg_op_e;

  // 6-bit register map, anything else reads 0xff
  typedef enum logic [5:0] {
    ra_ctrl     = 6'h11,  // bit 7 is compare / raster bit 8
    ra_raster   = 6'h12,  // compare low byte on write, live line on read
    ra_irq_stat = 6'h19,  // bit 0 raster irq, write 1 to clear
    ra_irq_en   = 6'h1A,  // bit 0 raster irq enable
    ra_border   = 6'h20,
    ra_bg       = 6'h21,
    ra_model    = 6'h3F   // bit 0 chip model
  } reg_addr_e;

  typedef struct packed {
    reg_op_e    op;
    logic [5:0] addr;    // raw address, may be unmapped
    logic [7:0] wdata;
  } reg_req_t;

  typedef struct packed {
    logic [7:0] rdata;
  } reg_rsp_t;

endpackage

/* common/vic_cfg.svh */
// vic timing and reset configuration
// line and frame geometry for both chip models, one raster position per clock
`ifndef VIC_CFG_SVH
`define VIC_CFG_SVH

// positions per raster line
`define VIC_PAL_LINE_LEN   63
`define VIC_NTSC_LINE_LEN  65

// lines per frame
`define VIC_PAL_LINES      312
`define VIC_NTSC_LINES     263

`define VIC_HSYNC_LEN      4     // positions from x = 0
`define VIC_VSYNC_LINES    3     // lines from line = 0

// display window, bounds inclusive
`define VIC_ACT_X0         16
`define VIC_ACT_X1         55
`define VIC_ACT_Y0         51
`define VIC_ACT_Y1         250

`define VIC_RST_BORDER     14    // light blue
`define VIC_RST_BG         6     // blue

`endif
